// ==== Makefile ====
TOP := multifunc_cfg_tb
SIM := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): sources.f $(wildcard source/*.sv) $(wildcard sim/*.sv)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sources.f

run: $(SIM) sim/multifunc_cfg_tests.txt
	$(SIM) | tee sim.log
	@if grep -q -F '*** TEST FAILED ***' sim.log; then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q -F '*** TEST PASSED ***' sim.log; then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// ==== sim/multifunc_cfg_asserts.sv ====
`timescale 1ns/1ns

module multifunc_cfg_asserts import mfc_pkg::*; (
    input logic      clk_pcie,
    input logic      rst,
    input logic      req_valid,
    input tlp_beat_t req_beat,
    input logic      cpl_valid,
    input logic      msix_valid_out,
    input logic      fwd_en
);

    logic req_sop;

    assign req_sop = req_valid && req_beat.sop;

    // decode, process, encode
    cpl_latency: assert property (@(posedge clk_pcie) disable iff (rst)
        cpl_valid == $past(req_sop, 3))
        else $error("cpl_valid does not follow a request beat by exactly 3 cycles");

    reset_quiet: assert property (@(posedge clk_pcie)
        rst |=> (!cpl_valid && !msix_valid_out))
        else $error("output valid while in reset");

    msix_gate: assert property (@(posedge clk_pcie) disable iff (rst)
        $rose(msix_valid_out) |-> $past(fwd_en))
        else $error("msix_valid_out rose with forwarding disabled");

endmodule

bind multifunc_cfg_top multifunc_cfg_asserts i_multifunc_cfg_asserts (
    .clk_pcie       (clk_pcie),
    .rst            (rst),
    .req_valid      (req_valid),
    .req_beat       (req_beat),
    .cpl_valid      (cpl_valid),
    .msix_valid_out (msix_valid_out),
    .fwd_en         (i_func_ctrl_regs.msix_fwd_en)
);

// ==== sim/multifunc_cfg_tb.sv ====
`timescale 1ns/1ns

module multifunc_cfg_tb import mfc_pkg::*; ();

    localparam logic [15:0] tb_pcie_id  = 16'h0300;
    localparam logic [15:0] tb_req_id   = 16'h0108;
    localparam logic [3:0]  tb_func_cnt = 4'd6;
    localparam int          drain_limit = 16;  // cycles

    // one expected completion per issued request
    typedef struct packed {
        logic [7:0]  ft;
        logic [9:0]  len;
        logic [2:0]  status;
        logic [7:0]  tag;
        logic [6:0]  laddr;
        logic [31:0] data;
        logic [31:0] cycle;
    } exp_cpl_t;

    logic                clk_pcie;
    logic                rst;
    logic [15:0]         pcie_id;
    logic [3:0]          function_count;
    logic                req_valid;
    tlp_beat_t           req_beat;
    logic                msix_valid_in;
    msix_msg_t           msix_in;
    logic                cpl_valid;
    logic [127:0]        cpl_beat;
    logic [func_max-1:0] function_status;
    logic [func_w-1:0]   current_function;
    logic                msix_valid_out;
    msix_msg_t           msix_out;
    logic [func_w-1:0]   msix_source_func;

    exp_cpl_t            pending[$];
    logic [31:0]         lfsr;
    logic [31:0]         cycle_cnt = '0;
    int                  func_cnt [func_max];  // accepted requests per function
    logic [func_max-1:0] model_mask;           // expected enable mask
    int                  last_func;
    int                  mismatches;
    int                  failures;
    int                  checked;

    multifunc_cfg_top i_multifunc_cfg_top (
        .rst              (rst),
        .clk_pcie         (clk_pcie),
        .pcie_id          (pcie_id),
        .function_count   (function_count),
        .req_valid        (req_valid),
        .req_beat         (req_beat),
        .msix_valid_in    (msix_valid_in),
        .msix_in          (msix_in),
        .cpl_valid        (cpl_valid),
        .cpl_beat         (cpl_beat),
        .function_status  (function_status),
        .current_function (current_function),
        .msix_valid_out   (msix_valid_out),
        .msix_out         (msix_out),
        .msix_source_func (msix_source_func)
    );

    initial begin
        clk_pcie = 1'b0;
        forever #10 clk_pcie = ~clk_pcie;
    end

    always @(posedge clk_pcie) cycle_cnt <= cycle_cnt + 32'd1;

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_tag(output logic [7:0] tag);
        for (int i = 0; i < 8; i++) begin
            lfsr   = lfsr_next(lfsr);
            tag[i] = lfsr[0];
        end
    endtask

    task automatic check_completion();
        exp_cpl_t exp;
        if (pending.size() == 0) begin
            failures++;
            $display("a completion arrived with no request outstanding");
        end else begin
            exp = pending.pop_front();
            checked++;
            check_value("cpl latency", 64'(cycle_cnt - exp.cycle), 64'd3);
            check_value("cpl fmt_type", 64'(cpl_beat[tlp_ft_lsb +: 8]), 64'(exp.ft));
            check_value("cpl length", 64'(cpl_beat[cpl_len_lsb +: 10]), 64'(exp.len));
            check_value("cpl byte count", 64'(cpl_beat[cpl_bc_lsb +: 12]), 64'd4);
            check_value("cpl status", 64'(cpl_beat[cpl_status_lsb +: 3]), 64'(exp.status));
            check_value("cpl completer id", 64'(cpl_beat[cpl_cid_lsb +: 16]), 64'(tb_pcie_id));
            check_value("cpl requester id", 64'(cpl_beat[cpl_rid_lsb +: 16]), 64'(tb_req_id));
            check_value("cpl tag", 64'(cpl_beat[cpl_tag_lsb +: 8]), 64'(exp.tag));
            check_value("cpl lower address", 64'(cpl_beat[cpl_laddr_lsb +: 7]), 64'(exp.laddr));
            if (exp.ft == ft_cpld) begin
                check_value("cpl data", 64'(cpl_beat[cpl_data_lsb +: 32]), 64'(exp.data));
            end
        end
    endtask

    always @(negedge clk_pcie) begin
        if (!rst && cpl_valid) begin
            check_completion();
        end
    end

    task automatic send_request(input logic [7:0] ft, input int func,
                                input logic [tlp_addr_w-1:0] addr, input logic [3:0] be,
                                input logic [31:0] wdata, input logic [2:0] status,
                                input logic [31:0] rdata);
        tlp_beat_t  beat;
        exp_cpl_t   exp;
        logic [7:0] tag;
        draw_tag(tag);
        beat     = '0;
        beat.sop = 1'b1;
        beat.data[tlp_ft_lsb +: 8]          = ft;
        beat.data[tlp_be_lsb +: 4]          = be;
        beat.data[tlp_tag_lsb +: 8]         = tag;
        beat.data[tlp_reqid_lsb +: 16]      = tb_req_id;
        beat.data[tlp_addr_lsb +: tlp_addr_w] = addr;
        beat.data[tlp_func_lsb +: func_w]   = func_w'(func);
        beat.data[tlp_data_lsb +: 32]       = wdata;
        // only a good read carries data
        exp.ft     = (ft == ft_cfg_rd0 && status == cpl_sc) ? ft_cpld : ft_cpl;
        exp.len    = (exp.ft == ft_cpld) ? 10'd1 : 10'd0;
        exp.status = status;
        exp.tag    = tag;
        exp.laddr  = {addr[6:2], 2'b00};
        exp.data   = rdata;
        @(negedge clk_pcie);
        exp.cycle = cycle_cnt;
        req_valid = 1'b1;
        req_beat  = beat;
        pending.push_back(exp);
    endtask

    task automatic drain(output logic ok);
        int waited;
        waited = 0;
        @(negedge clk_pcie);
        req_valid = 1'b0;
        do begin
            @(posedge clk_pcie);
            waited++;
        end while (pending.size() != 0 && waited < drain_limit);
        ok = (pending.size() == 0);
        if (!ok) begin
            failures++;
            $display("timeout: %0d completions still missing after %0d cycles",
                     pending.size(), drain_limit);
        end else begin
            @(negedge clk_pcie);  // pipeline empty, status outputs settled
            check_value("function_status", 64'(function_status), 64'(model_mask));
            check_value("current_function", 64'(current_function), 64'(last_func));
        end
    endtask

    task automatic send_msix(input logic [63:0] addr, input logic [31:0] data,
                             input logic fwd, input logic [func_w-1:0] src);
        @(negedge clk_pcie);
        msix_valid_in = 1'b1;
        msix_in.addr  = addr;
        msix_in.data  = data;
        @(negedge clk_pcie);
        msix_valid_in = 1'b0;
        check_value("msix_valid_out", 64'(msix_valid_out), 64'(fwd));
        if (fwd) begin
            check_value("msix_out.addr", msix_out.addr, addr);
            check_value("msix_out.data", 64'(msix_out.data), 64'(data));
            check_value("msix_source_func", 64'(msix_source_func), 64'(src));
        end
    endtask

    task automatic run_line(input string kind, input int sync_f, input int func_f,
                            input logic [31:0] addr_f, be_f, data_f, st_f, exp_f,
                            output logic ok);
        logic [31:0] rdata;
        logic        accepted;
        ok       = 1'b1;
        rdata    = exp_f;
        accepted = (st_f[2:0] == cpl_sc);
        if (kind == "msix") begin
            drain(ok);
            if (st_f[0] && func_f != last_func) begin
                failures++;
                $display("tests file expects source function %0d, model has %0d",
                         func_f, last_func);
            end
            send_msix(64'hFEE0_0000 | 64'(addr_f), data_f, st_f[0], func_w'(last_func));
        end else begin
            if (sync_f != 0) begin
                drain(ok);
            end
            // counter reads come from the local per-function count
            if (kind == "rd" && accepted && addr_f[11:0] == {2'b00, stat_dw_idx, 2'b00}) begin
                rdata = 32'(func_cnt[func_f]);
                if (exp_f != rdata) begin
                    failures++;
                    $display("tests file counter value %0d disagrees with model count %0d",
                             exp_f, rdata);
                end
            end
            if (kind == "rd") begin
                send_request(ft_cfg_rd0, func_f, addr_f[11:0], be_f[3:0], data_f, st_f[2:0], rdata);
            end else if (kind == "wr") begin
                send_request(ft_cfg_wr0, func_f, addr_f[11:0], be_f[3:0], data_f, st_f[2:0], rdata);
            end else if (kind == "badtype") begin
                send_request(8'h00, func_f, addr_f[11:0], be_f[3:0], data_f, st_f[2:0], rdata);
            end else begin
                failures++;
                $display("unknown request kind %s in tests file", kind);
            end
            if (accepted) begin
                func_cnt[func_f]++;
                last_func = func_f;
                // mask write limited to the implemented functions
                if (kind == "wr" && func_f == 0 && be_f[0]
                    && addr_f[11:0] == {2'b00, mask_dw_idx, 2'b00}) begin
                    model_mask = data_f[func_max-1:0] & func_max'((1 << tb_func_cnt) - 1);
                end
            end
        end
    endtask

    initial begin
        int          fd;
        int          n;
        string       line;
        string       kind;
        int          sync_f;
        int          func_f;
        logic [31:0] addr_f, be_f, data_f, st_f, exp_f;
        logic        ok;
        rst            = 1'b1;
        pcie_id        = tb_pcie_id;
        function_count = tb_func_cnt;
        req_valid      = 1'b0;
        req_beat       = '0;
        msix_valid_in  = 1'b0;
        msix_in        = '0;
        lfsr           = 32'h1f53;
        mismatches     = 0;
        failures       = 0;
        checked        = 0;
        last_func      = 0;
        model_mask     = 8'h01;
        ok             = 1'b1;
        foreach (func_cnt[i]) func_cnt[i] = 0;
        repeat (4) @(posedge clk_pcie);
        @(negedge clk_pcie);
        rst = 1'b0;

        fd = $fopen("sim/multifunc_cfg_tests.txt", "r");
        if (fd == 0) begin
            failures++;
            $display("could not open sim/multifunc_cfg_tests.txt");
        end else begin
            while (ok && !$feof(fd)) begin
                line = "";
                n    = $fgets(line, fd);
                if (n > 1 && line[0] != "#") begin  // skip blanks and comments
                    n = $sscanf(line, "%s %d %d %h %h %h %h %h", kind, sync_f, func_f,
                                addr_f, be_f, data_f, st_f, exp_f);
                    if (n != 8) begin
                        failures++;
                        $display("malformed line in tests file: %s", line);
                    end else begin
                        run_line(kind, sync_f, func_f, addr_f, be_f, data_f, st_f, exp_f, ok);
                    end
                end
            end
            $fclose(fd);
        end
        if (ok) begin
            drain(ok);
        end
        if (checked == 0) begin
            failures++;
            $display("no completions were checked");
        end

        $display("summary: %0d value mismatches, %0d other failures, %0d completions checked",
                 mismatches, failures, checked);
        if (mismatches == 0 && failures == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== sim/multifunc_cfg_tests.txt ====
# kind sync func byte_addr(hex) be(hex) data(hex) status exp_data(hex)
# status 0 = SC, 1 = UR; for msix it is 1 when forwarded, func is the expected source
rd      0 0 000 f 00000000 0 70201a2b
wr      0 0 00c f 11223344 0 00000000
wr      0 0 00c 5 aabbccdd 0 00000000
rd      0 0 00c f 00000000 0 11bb33dd
wr      0 0 000 f deadbeef 0 00000000
rd      0 0 000 f 00000000 0 70201a2b
rd      0 0 0a0 f 00000000 0 00000000
rd      0 0 3e8 f 00000000 0 00000007
rd      1 2 004 f 00000000 1 00000000
wr      0 2 004 f 12345678 1 00000000
rd      0 6 000 f 00000000 1 00000000
rd      0 7 000 f 00000000 1 00000000
rd      0 0 00e f 00000000 1 00000000
rd      0 0 400 f 00000000 1 00000000
badtype 0 0 000 f 00000000 1 00000000
wr      0 0 3e4 1 000000ff 0 00000000
rd      0 0 3e4 f 00000000 0 0000003f
rd      0 2 004 f 00000000 0 00000000
wr      0 2 008 f cafef00d 0 00000000
rd      0 2 008 f 00000000 0 cafef00d
rd      0 2 000 f 00000000 0 70221a2b
rd      0 0 00c f 00000000 0 11bb33dd
wr      0 5 3e8 f 0000ffff 0 00000000
rd      0 5 3e8 f 00000000 0 00000001
rd      0 2 3e8 f 00000000 0 00000004
rd      0 0 3e0 f 00000000 0 00000000
msix    1 2 000 0 0badf00d 0 00000000
wr      1 0 3e0 2 00000100 0 00000000
rd      0 0 3e0 f 00000000 0 00000100
msix    1 0 010 0 12345678 1 00000000
rd      0 3 004 f 00000000 0 00000000
msix    1 3 020 0 9abcdef0 1 00000000
rd      0 0 3e8 f 00000000 0 0000000e
rd      0 3 3e8 f 00000000 0 00000001

// ==== source/cfg_cpl_encode.sv ====
`timescale 1ns/1ns

module cfg_cpl_encode import mfc_pkg::*; (
    input  logic         clk_pcie,
    input  logic         rst,
    input  logic [15:0]  pcie_id,
    input  logic         rsp_valid,
    input  cfg_rsp_t     rsp,
    input  logic [31:0]  ctl_rd_data,
    output logic         cpl_valid,
    output logic [127:0] cpl_beat
);

    logic [31:0]  data_sel;
    logic         is_read;
    logic [2:0]   status;
    logic [127:0] beat;

    always_comb begin
        is_read  = 1'b1;
        data_sel = '0;
        case (rsp.op)
            op_cfg_rd:  data_sel = rsp.rd_data;
            op_ctl_rd:  data_sel = ctl_rd_data;
            op_stat_rd: data_sel = ctl_rd_data;
            default:    is_read  = 1'b0;  // writes and bad requests, no payload
        endcase
    end

    assign status = (rsp.op == op_bad) ? cpl_ur : cpl_sc;

    always_comb begin
        beat = '0;
        beat[tlp_ft_lsb +: 8]     = is_read ? ft_cpld : ft_cpl;
        beat[cpl_len_lsb +: 10]   = is_read ? 10'd1 : 10'd0;
        beat[cpl_bc_lsb +: 12]    = 12'd4;
        beat[cpl_status_lsb +: 3] = status;
        beat[cpl_cid_lsb +: 16]   = pcie_id;
        beat[cpl_laddr_lsb +: 7]  = {rsp.dw_idx[4:0], 2'b00};  // byte address low bits
        beat[cpl_tag_lsb +: 8]    = rsp.tag;
        beat[cpl_rid_lsb +: 16]   = rsp.reqid;
        beat[cpl_data_lsb +: 32]  = data_sel;
    end

    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            cpl_valid <= 1'b0;
        end else begin
            cpl_valid <= rsp_valid;
        end
    end

    always_ff @(posedge clk_pcie) begin
        cpl_beat <= beat;
    end

endmodule

// ==== source/cfg_req_decode.sv ====
`timescale 1ns/1ns

module cfg_req_decode import mfc_pkg::*; (
    input  logic                clk_pcie,
    input  logic                rst,
    input  logic                req_valid,
    input  tlp_beat_t           req_beat,
    input  logic [3:0]          function_count,
    input  logic [func_max-1:0] enable_mask,
    output logic                dec_valid,
    output cfg_req_t            dec_req
);

    logic [7:0]            fmt_type;
    logic [tlp_addr_w-1:0] byte_addr;
    logic [func_w-1:0]     func;
    logic [dw_idx_w-1:0]   dw_idx;
    logic                  is_rd;
    logic                  is_wr;
    logic                  addr_ok;
    logic                  func_ok;
    req_op_t               op;

    assign fmt_type  = req_beat.data[tlp_ft_lsb +: 8];
    assign byte_addr = req_beat.data[tlp_addr_lsb +: tlp_addr_w];
    assign func      = req_beat.data[tlp_func_lsb +: func_w];
    assign dw_idx    = byte_addr[2 +: dw_idx_w];

    assign is_rd   = (fmt_type == ft_cfg_rd0);
    assign is_wr   = (fmt_type == ft_cfg_wr0);
    assign addr_ok = (byte_addr[1:0] == 2'b00) && (byte_addr < tlp_addr_w'(cfg_space_lim));
    assign func_ok = ({1'b0, func} < function_count) && enable_mask[func];

    always_comb begin
        op = op_bad;
        if ((is_rd || is_wr) && addr_ok && func_ok) begin
            if (dw_idx == stat_dw_idx) begin
                op = is_rd ? op_stat_rd : op_ctl_wr;  // counter writes dropped later
            end else if (func == '0 && (dw_idx == ctrl_dw_idx || dw_idx == mask_dw_idx)) begin
                op = is_rd ? op_ctl_rd : op_ctl_wr;
            end else begin
                op = is_rd ? op_cfg_rd : op_cfg_wr;
            end
        end
    end

    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= req_valid && req_beat.sop;  // continuation beats ignored
        end
    end

    always_ff @(posedge clk_pcie) begin
        dec_req.op     <= op;
        dec_req.func   <= func;
        dec_req.dw_idx <= dw_idx;
        dec_req.be     <= req_beat.data[tlp_be_lsb +: 4];
        dec_req.data   <= req_beat.data[tlp_data_lsb +: 32];
        dec_req.tag    <= req_beat.data[tlp_tag_lsb +: 8];
        dec_req.reqid  <= req_beat.data[tlp_reqid_lsb +: 16];
    end

endmodule

// ==== source/func_cfg_store.sv ====
`timescale 1ns/1ns

module func_cfg_store import mfc_pkg::*; (
    input  logic     clk_pcie,
    input  logic     rst,
    input  logic     dec_valid,
    input  cfg_req_t dec_req,
    output logic     rsp_valid,
    output cfg_rsp_t rsp
);

    // one bank of dwords per function, dword 0 slot unused
    logic [31:0] mem [func_max][cfg_dwords];

    logic [cfg_idx_w-1:0] idx;
    logic                 in_store;
    logic                 wr_hit;
    logic [31:0]          rd_data;

    assign idx      = dec_req.dw_idx[cfg_idx_w-1:0];
    assign in_store = (dec_req.dw_idx < dw_idx_w'(cfg_dwords));
    assign wr_hit   = dec_valid && (dec_req.op == op_cfg_wr) && in_store
                      && (dec_req.dw_idx != '0);  // ID dword is read only

    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            for (int f = 0; f < func_max; f++) begin
                for (int d = 0; d < cfg_dwords; d++) begin
                    mem[f][d] <= '0;
                end
            end
        end else if (wr_hit) begin
            for (int b = 0; b < 4; b++) begin
                if (dec_req.be[b]) begin
                    mem[dec_req.func][idx][8*b +: 8] <= dec_req.data[8*b +: 8];
                end
            end
        end
    end

    // read path sees writes from earlier cycles
    always_comb begin
        if (dec_req.dw_idx == '0) begin
            rd_data = {device_id_base + 16'(dec_req.func), vendor_id_base};
        end else if (in_store) begin
            rd_data = mem[dec_req.func][idx];
        end else begin
            rd_data = '0;  // unimplemented dwords
        end
    end

    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= dec_valid;
        end
    end

    // whole request carried to the encoder
    always_ff @(posedge clk_pcie) begin
        rsp.op      <= dec_req.op;
        rsp.tag     <= dec_req.tag;
        rsp.reqid   <= dec_req.reqid;
        rsp.dw_idx  <= dec_req.dw_idx;
        rsp.rd_data <= rd_data;
    end

endmodule

// ==== source/func_ctrl_regs.sv ====
`timescale 1ns/1ns

module func_ctrl_regs import mfc_pkg::*; (
    input  logic                clk_pcie,
    input  logic                rst,
    input  logic                dec_valid,
    input  cfg_req_t            dec_req,
    input  logic [3:0]          function_count,
    output logic [func_max-1:0] enable_mask,
    output logic [31:0]         ctl_rd_data,
    output logic [func_w-1:0]   current_function,
    input  logic                msix_valid_in,
    input  msix_msg_t           msix_in,
    output logic                msix_valid_out,
    output msix_msg_t           msix_out,
    output logic [func_w-1:0]   msix_source_func
);

    logic              msix_fwd_en;
    logic [15:0]       acc_cnt [func_max];
    logic [func_max:0] fc_lim;
    logic              accept;

    // mask of implemented functions
    assign fc_lim = ({{func_max{1'b0}}, 1'b1} << function_count) - 1'b1;
    assign accept = dec_valid && (dec_req.op != op_bad);

    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            msix_fwd_en      <= 1'b0;
            enable_mask      <= 8'h01;  // function 0 only
            current_function <= '0;
            for (int f = 0; f < func_max; f++) begin
                acc_cnt[f] <= '0;
            end
        end else if (accept) begin
            acc_cnt[dec_req.func] <= acc_cnt[dec_req.func] + 16'd1;
            current_function      <= dec_req.func;
            if (dec_req.op == op_ctl_wr) begin
                if (dec_req.dw_idx == ctrl_dw_idx) begin
                    if (dec_req.be[ctrl_en_bit/8]) begin
                        msix_fwd_en <= dec_req.data[ctrl_en_bit];
                    end
                end else if (dec_req.dw_idx == mask_dw_idx) begin
                    if (dec_req.be[0]) begin
                        enable_mask <= dec_req.data[func_max-1:0] & fc_lim[func_max-1:0];
                    end
                end
                // writes to the counter dword have no effect
            end
        end
    end

    // counter value is taken before this request's increment
    always_ff @(posedge clk_pcie) begin
        case (dec_req.dw_idx)
            ctrl_dw_idx: ctl_rd_data <= 32'(msix_fwd_en) << ctrl_en_bit;
            mask_dw_idx: ctl_rd_data <= 32'(enable_mask);
            stat_dw_idx: ctl_rd_data <= {16'h0, acc_cnt[dec_req.func]};
            default:     ctl_rd_data <= '0;
        endcase
    end

    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            msix_valid_out <= 1'b0;
        end else begin
            msix_valid_out <= msix_valid_in && msix_fwd_en;
        end
    end

    always_ff @(posedge clk_pcie) begin
        msix_out         <= msix_in;
        msix_source_func <= current_function;  // last accepted request
    end

endmodule

// ==== source/mfc_pkg.sv ====
package mfc_pkg;

    // function and dword sizing
    localparam int func_w     = 3;
    localparam int func_max   = 8;
    localparam int dw_idx_w   = 8;
    localparam int cfg_dwords = 16;
    localparam int cfg_idx_w  = $clog2(cfg_dwords);

    localparam logic [dw_idx_w-1:0] ctrl_dw_idx = 8'hF8;  // msix forwarding control
    localparam logic [dw_idx_w-1:0] mask_dw_idx = 8'hF9;  // function enable mask
    localparam logic [dw_idx_w-1:0] stat_dw_idx = 8'hFA;  // per-function access counter
    localparam int                  ctrl_en_bit = 8;      // forwarding enable in 0xF8

    localparam logic [15:0] vendor_id_base = 16'h1A2B;
    localparam logic [15:0] device_id_base = 16'h7020;  // plus function number

    localparam logic [2:0] cpl_sc = 3'b000;
    localparam logic [2:0] cpl_ur = 3'b001;

    // request header layout, bit positions in the 128-bit beat
    localparam int tlp_ft_lsb    = 24;   // fmt/type byte
    localparam int tlp_be_lsb    = 32;   // first dword byte enables
    localparam int tlp_tag_lsb   = 40;
    localparam int tlp_reqid_lsb = 48;
    localparam int tlp_addr_lsb  = 64;   // byte address
    localparam int tlp_addr_w    = 12;
    localparam int tlp_func_lsb  = 76;
    localparam int tlp_data_lsb  = 96;
    localparam int cfg_space_lim = 'h400;

    localparam logic [7:0] ft_cfg_rd0 = 8'h04;
    localparam logic [7:0] ft_cfg_wr0 = 8'h44;
    localparam logic [7:0] ft_cpl     = 8'h0A;
    localparam logic [7:0] ft_cpld    = 8'h4A;

    // completion layout, fmt/type shares tlp_ft_lsb
    localparam int cpl_len_lsb    = 0;   // 10 bits
    localparam int cpl_bc_lsb     = 32;  // 12 bits
    localparam int cpl_status_lsb = 45;
    localparam int cpl_cid_lsb    = 48;
    localparam int cpl_laddr_lsb  = 64;  // 7 bits
    localparam int cpl_tag_lsb    = 72;
    localparam int cpl_rid_lsb    = 80;
    localparam int cpl_data_lsb   = 96;

    typedef enum logic [2:0] {
        op_cfg_rd,
        op_cfg_wr,
        op_ctl_rd,
        op_ctl_wr,
        op_stat_rd,
        op_bad
    } req_op_t;

    typedef struct packed {
        req_op_t             op;
        logic [func_w-1:0]   func;
        logic [dw_idx_w-1:0] dw_idx;
        logic [3:0]          be;
        logic [31:0]         data;
        logic [7:0]          tag;
        logic [15:0]         reqid;
    } cfg_req_t;

    typedef struct packed {
        req_op_t             op;
        logic [7:0]          tag;
        logic [15:0]         reqid;
        logic [dw_idx_w-1:0] dw_idx;
        logic [31:0]         rd_data;
    } cfg_rsp_t;

    typedef struct packed {
        logic [127:0] data;
        logic         sop;
    } tlp_beat_t;

    typedef struct packed {
        logic [63:0] addr;
        logic [31:0] data;
    } msix_msg_t;

endpackage

// ==== source/multifunc_cfg_top.sv ====
`timescale 1ns/1ns

module multifunc_cfg_top import mfc_pkg::*; (
    input  logic                rst,
    input  logic                clk_pcie,
    input  logic [15:0]         pcie_id,
    input  logic [3:0]          function_count,
    input  logic                req_valid,
    input  tlp_beat_t           req_beat,
    input  logic                msix_valid_in,
    input  msix_msg_t           msix_in,
    output logic                cpl_valid,
    output logic [127:0]        cpl_beat,
    output logic [func_max-1:0] function_status,
    output logic [func_w-1:0]   current_function,
    output logic                msix_valid_out,
    output msix_msg_t           msix_out,
    output logic [func_w-1:0]   msix_source_func
);

    logic        dec_valid;
    cfg_req_t    dec_req;
    logic        rsp_valid;
    cfg_rsp_t    rsp;
    logic [31:0] ctl_rd_data;

    cfg_req_decode i_cfg_req_decode (
        .clk_pcie       (clk_pcie),
        .rst            (rst),
        .req_valid      (req_valid),
        .req_beat       (req_beat),
        .function_count (function_count),
        .enable_mask    (function_status),  // enable mask fed back from control block
        .dec_valid      (dec_valid),
        .dec_req        (dec_req)
    );

    func_cfg_store i_func_cfg_store (
        .clk_pcie  (clk_pcie),
        .rst       (rst),
        .dec_valid (dec_valid),
        .dec_req   (dec_req),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    func_ctrl_regs i_func_ctrl_regs (
        .clk_pcie         (clk_pcie),
        .rst              (rst),
        .dec_valid        (dec_valid),
        .dec_req          (dec_req),
        .function_count   (function_count),
        .enable_mask      (function_status),
        .ctl_rd_data      (ctl_rd_data),
        .current_function (current_function),
        .msix_valid_in    (msix_valid_in),
        .msix_in          (msix_in),
        .msix_valid_out   (msix_valid_out),
        .msix_out         (msix_out),
        .msix_source_func (msix_source_func)
    );

    cfg_cpl_encode i_cfg_cpl_encode (
        .clk_pcie    (clk_pcie),
        .rst         (rst),
        .pcie_id     (pcie_id),
        .rsp_valid   (rsp_valid),
        .rsp         (rsp),
        .ctl_rd_data (ctl_rd_data),
        .cpl_valid   (cpl_valid),
        .cpl_beat    (cpl_beat)
    );

endmodule

// ==== sources.f ====
source/mfc_pkg.sv
source/cfg_req_decode.sv
source/func_cfg_store.sv
source/func_ctrl_regs.sv
source/cfg_cpl_encode.sv
source/multifunc_cfg_top.sv
sim/multifunc_cfg_asserts.sv
sim/multifunc_cfg_tb.sv
